//--- design/zclk_defs.svh
`ifndef ZCLK_DEFS_SVH
`define ZCLK_DEFS_SVH

// one DRAM cycle is four fclk periods, so two bits of phase
`define ZCLK_PHASE_W 2

// phase at which each cycle strobe is raised
`define PH_CBEG     2'd0 // start of the DRAM cycle
`define PH_PRE_CEND 2'd2 // one before the end, feeds zpos
`define PH_CEND     2'd3 // last phase, slot decision is taken here

// cpu speed after reset is 3.5 MHz
`define TURBO_RESET 2'b00

`endif

//--- design/zclk_pkg.sv
`default_nettype none

`include "zclk_defs.svh"

package zclk_pkg;

	// requested z80 speed
	// 00 is 3.5 MHz, anything else runs at 7 MHz
	typedef logic [1:0] turbo_t;

	// position inside a 4-cycle DRAM cycle
	typedef logic [`ZCLK_PHASE_W-1:0] phase_t;

	// who owns the current DRAM cycle
	typedef enum logic
	{
		SLOT_CPU   = 1'b0,
		SLOT_VIDEO = 1'b1
	} slot_state_t;

endpackage

`default_nettype wire

//--- design/dram_phase.sv
`timescale 1ns/1ps
`default_nettype none

`include "zclk_defs.svh"

module dram_phase (
	input  wire  fclk,
	input  wire  rst,
	output logic cbeg,     // phase 0
	output logic pre_cend, // phase 2
	output logic cend      // phase 3
);
	import zclk_pkg::*;

	phase_t phase;     // current position in the DRAM cycle
	phase_t phase_nxt;

	assign phase_nxt = phase + phase_t'(1); // wraps 3 -> 0

	// counter parks on the last phase during reset,
	// so the first active cycle is phase 0 with cbeg up
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			phase    <= `PH_CEND;
			cbeg     <= 1'b0;
			pre_cend <= 1'b0;
			cend     <= 1'b0;
		end
		else
		begin
			phase    <= phase_nxt;
			// strobes decoded from the next phase so they line up with phase
			cbeg     <= (phase_nxt == `PH_CBEG);
			pre_cend <= (phase_nxt == `PH_PRE_CEND);
			cend     <= (phase_nxt == `PH_CEND);
		end
	end

	// at most one strobe per fclk
	a_one_strobe: assert property (@(posedge fclk) disable iff (rst)
		$onehot0({cbeg, pre_cend, cend}))
		else $error("dram_phase: more than one cycle strobe high");

endmodule

`default_nettype wire

//--- design/slot_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module slot_arbiter (
	input  wire  fclk,
	input  wire  rst,
	input  wire  cend,         // last phase of the DRAM cycle
	input  wire  video_active, // video fetches wanted in this line
	input  wire  cpu_req,      // z80 wants a memory access
	output logic zclk_stall,   // hold the z80 clock for one DRAM cycle
	output logic cpu_grant     // one-cycle grant at the end of a cpu slot
);
	import zclk_pkg::*;

	slot_state_t owner;     // owner of the cycle now running
	slot_state_t owner_nxt; // owner of the cycle starting after cend
	logic        slot_par;  // odd DRAM cycles may go to video
	logic        stall_nxt;

	// video takes every other cycle, and only while it is active
	assign owner_nxt = (video_active && !slot_par) ? SLOT_VIDEO : SLOT_CPU;

	// a cpu access landing on a video slot has to wait the whole cycle
	assign stall_nxt = (owner_nxt == SLOT_VIDEO) && cpu_req;

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			owner    <= SLOT_CPU;
			slot_par <= 1'b0; // first slot belongs to the cpu
		end
		else if (cend)
		begin
			owner    <= owner_nxt;
			slot_par <= ~slot_par; // flips once per DRAM cycle
		end
	end

	// stall is only ever loaded at cend,
	// then holds for the four phases of the new cycle
	always_ff @(posedge fclk)
	begin
		if (rst)
			zclk_stall <= 1'b0;
		else if (cend)
			zclk_stall <= stall_nxt;
	end

	// grant while cend of a cpu slot is on the bus
	assign cpu_grant = cend && (owner == SLOT_CPU) && cpu_req;

	// stall edges only right after a slot decision
	a_stall_at_cend: assert property (@(posedge fclk) disable iff (rst)
		$changed(zclk_stall) |-> $past(cend))
		else $error("slot_arbiter: zclk_stall moved outside a cend boundary");

endmodule

`default_nettype wire

//--- design/zclock.sv
`timescale 1ns/1ps
`default_nettype none

`include "zclk_defs.svh"

module zclock (
	input  wire             fclk,
	input  wire             rst,
	input  wire             rfsh_n,     // refresh part of m1, mode switch point
	input  wire zclk_pkg::turbo_t turbo, // requested speed
	input  wire             cbeg,       // DRAM cycle start
	input  wire             pre_cend,   // one before DRAM cycle end
	input  wire             zclk_stall, // drop pulses for this DRAM cycle
	output logic            zpos,       // z80 clock rising edge marker
	output logic            zneg,       // z80 clock falling edge marker
	output logic            zclk_out    // z80 clock level
);
	import zclk_pkg::*;

	logic   prec_tgl;  // halves pre_cend
	logic   h1;        // pre_cend with toggle set
	logic   h2;        // pre_cend with toggle clear
	logic   old_rfsh_n; // rfsh_n at the previous zpos
	turbo_t int_turbo;  // mode actually in use
	logic   fast;       // 7 MHz
	logic   pre_zpos;
	logic   pre_zneg;

	// every other pre_cend, giving 8-cycle spacing
	always_ff @(posedge fclk)
	begin
		if (rst)
			prec_tgl <= 1'b0;
		else if (pre_cend)
			prec_tgl <= ~prec_tgl;
	end

	assign h1 = pre_cend && prec_tgl;
	assign h2 = pre_cend && !prec_tgl;

	// mode is picked up only on a falling rfsh_n seen between two zpos,
	// so the z80 clock never changes speed mid bus cycle
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			old_rfsh_n <= 1'b1;
			int_turbo  <= `TURBO_RESET;
		end
		else if (zpos)
		begin
			old_rfsh_n <= rfsh_n;
			if (old_rfsh_n && !rfsh_n)
				int_turbo <= turbo;
		end
	end

	// 14 MHz is not built, both upper codes fall back to 7 MHz
	assign fast = |int_turbo;

	// 7 MHz: both edges every DRAM cycle
	// 3.5 MHz: one edge per DRAM cycle, alternating
	assign pre_zpos = fast ? pre_cend : h2;
	assign pre_zneg = fast ? cbeg     : h1;

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			zpos <= 1'b0;
			zneg <= 1'b0;
		end
		else
		begin
			zpos <= pre_zpos && !zclk_stall; // stalled cycles lose their pulses
			zneg <= pre_zneg && !zclk_stall;
		end
	end

	// clock level, one fclk behind the pulses
	always_ff @(posedge fclk)
	begin
		if (rst)
			zclk_out <= 1'b1; // z80 clock idles high
		else if (zpos)
			zclk_out <= 1'b0;
		else if (zneg)
			zclk_out <= 1'b1;
	end

	// the two edge markers never collide
	a_pos_neg_excl: assert property (@(posedge fclk) disable iff (rst)
		!(zpos && zneg))
		else $error("zclock: zpos and zneg high together");

	// a stall window from the arbiter swallows both markers
	a_stall_kills_pulses: assert property (@(posedge fclk) disable iff (rst)
		$past(zclk_stall) |-> !zpos && !zneg)
		else $error("zclock: pulse leaked through a stall");

endmodule

`default_nettype wire

//--- design/zclk_top.sv
`timescale 1ns/1ps
`default_nettype none

module zclk_top (
	input  wire              fclk,         // 28 MHz
	input  wire              rst,
	input  wire              rfsh_n,
	input  wire zclk_pkg::turbo_t turbo,
	input  wire              video_active,
	input  wire              cpu_req,
	output logic             zpos,
	output logic             zneg,
	output logic             zclk_out,
	output logic             cpu_grant
);

	logic cbeg;       // DRAM cycle strobes
	logic pre_cend;
	logic cend;
	logic zclk_stall; // arbiter to clock generator

	// 4-phase DRAM cycle timing
	dram_phase u_phase (
		.fclk     (fclk),
		.rst      (rst),
		.cbeg     (cbeg),
		.pre_cend (pre_cend),
		.cend     (cend)
	);

	// video/cpu slot split, produces the stall
	slot_arbiter u_arb (
		.fclk         (fclk),
		.rst          (rst),
		.cend         (cend),
		.video_active (video_active),
		.cpu_req      (cpu_req),
		.zclk_stall   (zclk_stall),
		.cpu_grant    (cpu_grant)
	);

	// z80 clock edges and level
	zclock u_zclk (
		.fclk       (fclk),
		.rst        (rst),
		.rfsh_n     (rfsh_n),
		.turbo      (turbo),
		.cbeg       (cbeg),
		.pre_cend   (pre_cend),
		.zclk_stall (zclk_stall),
		.zpos       (zpos),
		.zneg       (zneg),
		.zclk_out   (zclk_out)
	);

endmodule

`default_nettype wire

//--- tests/tb_zclk.sv
`timescale 1ns/1ps
`default_nettype none

`include "zclk_defs.svh"

module tb_zclk;
	import zclk_pkg::*;

	localparam int CLK_PERIOD    = 20;
	localparam int DRIVE_DLY     = 2;  // inputs move this long after posedge
	localparam int RESET_CYCLES  = 16;
	localparam int T1_CYCLES     = 40;
	localparam int T2_CYCLES     = 96;
	localparam int T3_CYCLES     = 200;
	localparam int T4_CYCLES     = 120;
	localparam int T5_CYCLES     = 4000;
	localparam int MARGIN_CYCLES = 400;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
		+ T4_CYCLES + T5_CYCLES + MARGIN_CYCLES;

	logic   fclk;
	logic   rst;
	logic   rfsh_n;
	turbo_t turbo;
	logic   video_active;
	logic   cpu_req;
	logic   zpos;
	logic   zneg;
	logic   zclk_out;
	logic   cpu_grant;

	int     seed;
	int     err_cnt;      // all failures so far
	int     chk_cnt;
	int     test_num;
	int     test_err_base; // err_cnt when the current test started
	int     failed_tests;
	logic   checking;     // model compare enabled

	// reference model state
	logic [1:0] m_phase;
	logic       m_live;      // low while reset holds the strobes off
	logic       m_vid_owner; // running DRAM cycle belongs to video
	logic       m_par;       // slot alternation toggle
	logic       m_stall;
	logic       m_tgl;       // pre_cend halving
	logic       m_old_rfsh;  // rfsh_n at last zpos
	turbo_t     m_mode;
	logic       m_zpos;
	logic       m_zneg;
	logic       m_zclk;
	logic       exp_grant;

	zclk_top u_dut (
		.fclk         (fclk),
		.rst          (rst),
		.rfsh_n       (rfsh_n),
		.turbo        (turbo),
		.video_active (video_active),
		.cpu_req      (cpu_req),
		.zpos         (zpos),
		.zneg         (zneg),
		.zclk_out     (zclk_out),
		.cpu_grant    (cpu_grant)
	);

	initial
	begin
		fclk = 1'b0;
		forever #(CLK_PERIOD / 2) fclk = ~fclk;
	end

	// grant is combinational on cpu_req, so it uses the live input
	assign exp_grant = m_live && (m_phase == `PH_CEND) && !m_vid_owner && cpu_req;

	// cycle model advanced on the same edge as the DUT
	always @(posedge fclk)
	begin
		logic cb;
		logic pc;
		logic ce;
		logic fast;
		logic take_video;
		logic n_zpos;
		logic n_zneg;
		logic n_zclk;
		cb = m_live && (m_phase == `PH_CBEG);
		pc = m_live && (m_phase == `PH_PRE_CEND);
		ce = m_live && (m_phase == `PH_CEND);
		if (rst)
		begin
			m_phase     = `PH_CEND; // so the first live cycle is phase 0
			m_live      = 1'b0;
			m_vid_owner = 1'b0;
			m_par       = 1'b0;
			m_stall     = 1'b0;
			m_tgl       = 1'b0;
			m_old_rfsh  = 1'b1;
			m_mode      = `TURBO_RESET;
			m_zpos      = 1'b0;
			m_zneg      = 1'b0;
			m_zclk      = 1'b1;
		end
		else
		begin
			fast       = (m_mode != 2'b00); // 7 MHz for every nonzero code
			take_video = video_active && !m_par;
			n_zpos     = (fast ? pc : (pc && !m_tgl)) && !m_stall;
			n_zneg     = (fast ? cb : (pc && m_tgl)) && !m_stall;
			n_zclk     = m_zpos ? 1'b0 : (m_zneg ? 1'b1 : m_zclk);
			if (m_zpos)
			begin
				if (m_old_rfsh && !rfsh_n)
					m_mode = turbo; // refresh edge between two zpos
				m_old_rfsh = rfsh_n;
			end
			if (ce)
			begin
				m_vid_owner = take_video;
				m_stall     = take_video && cpu_req;
				m_par       = !m_par;
			end
			if (pc)
				m_tgl = !m_tgl;
			m_zpos  = n_zpos;
			m_zneg  = n_zneg;
			m_zclk  = n_zclk;
			m_phase = m_phase + 2'd1;
			m_live  = 1'b1;
		end
	end

	task automatic report_value(input string sig, input logic [31:0] dut_val,
		input logic [31:0] exp_val);
	begin
		$display("MISMATCH %s at %0t: dut=%h expected=%h", sig, $time, dut_val, exp_val);
		err_cnt++;
	end
	endtask

	// outputs have settled by the negedge
	always @(negedge fclk)
	begin
		if (checking)
		begin
			chk_cnt++;
			if (zpos !== m_zpos)
				report_value("zpos", 32'(zpos), 32'(m_zpos));
			if (zneg !== m_zneg)
				report_value("zneg", 32'(zneg), 32'(m_zneg));
			if (zclk_out !== m_zclk)
				report_value("zclk_out", 32'(zclk_out), 32'(m_zclk));
			if (cpu_grant !== exp_grant)
				report_value("cpu_grant", 32'(cpu_grant), 32'(exp_grant));
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("run stopped by watchdog after %0d cycles, tests did not finish",
			WATCHDOG_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	task automatic tick;
	begin
		@(posedge fclk);
		#DRIVE_DLY;
	end
	endtask

	// distance between two pulses of one kind
	task automatic check_gap(input string sig, input int now, inout int last, input int gap);
	begin
		chk_cnt++;
		if (last >= 0 && now - last != gap)
			report_value(sig, 32'(now - last), 32'(gap));
		last = now;
	end
	endtask

	task automatic end_test(input string name);
	begin
		if (err_cnt == test_err_base)
			$display("test %0d %s: ok", test_num, name);
		else
		begin
			$display("test %0d %s: %0d errors", test_num, name, err_cnt - test_err_base);
			failed_tests++;
		end
		test_num++;
		test_err_base = err_cnt;
	end
	endtask

	initial
	begin
		int          i;
		int          first_pos;
		int          first_neg;
		int          first_low;
		int          last_pos;
		int          last_neg;
		int          n_pos;
		int          n_neg;
		int          n_grant;
		int          rfsh_left;
		int          vid_left;
		logic        prev_pos;
		logic        prev_neg;
		logic [31:0] rnd;
		seed          = 7529;
		err_cnt       = 0;
		chk_cnt       = 0;
		test_num      = 1;
		test_err_base = 0;
		failed_tests  = 0;
		checking      = 1'b0;
		rst           = 1'b1;
		rfsh_n        = 1'b1;
		turbo         = `TURBO_RESET;
		video_active  = 1'b0;
		cpu_req       = 1'b0;

		// test 1 checks reset values and the first edges at 3.5 MHz
		for (i = 0; i < RESET_CYCLES; i++)
		begin
			tick();
			checking = 1'b1;
			chk_cnt++;
			if (zpos !== 1'b0 || zneg !== 1'b0 || cpu_grant !== 1'b0 || zclk_out !== 1'b1)
			begin
				$display("outputs not at reset values during reset at %0t", $time);
				err_cnt++;
			end
		end
		rst       = 1'b0;
		first_pos = -1;
		first_neg = -1;
		first_low = -1;
		for (i = 0; i < T1_CYCLES; i++)
		begin
			tick();
			if (i == 0 && u_dut.cbeg !== 1'b1)
				report_value("cbeg", 32'(u_dut.cbeg), 32'h1);
			if (zpos && first_pos < 0)
				first_pos = i;
			if (zneg && first_neg < 0)
				first_neg = i;
			if (!zclk_out && first_low < 0)
				first_low = i;
		end
		// pre_cend at 2 gives zpos at 3 and the second one at 6 gives zneg at 7
		if (first_pos != 3)
			report_value("first zpos cycle", 32'(first_pos), 32'd3);
		if (first_neg != 7)
			report_value("first zneg cycle", 32'(first_neg), 32'd7);
		if (first_low != 4)
			report_value("first zclk_out low cycle", 32'(first_low), 32'd4);
		end_test("reset state");

		// test 2 runs at 3.5 MHz without video
		last_pos = -1;
		last_neg = -1;
		n_pos    = 0;
		prev_pos = 1'b0;
		prev_neg = 1'b0;
		for (i = 0; i < T2_CYCLES; i++)
		begin
			tick();
			if (prev_pos && zclk_out !== 1'b0)
				report_value("zclk_out after zpos", 32'(zclk_out), 32'h0);
			if (prev_neg && zclk_out !== 1'b1)
				report_value("zclk_out after zneg", 32'(zclk_out), 32'h1);
			if (zpos)
			begin
				check_gap("zpos spacing", i, last_pos, 8);
				n_pos++;
			end
			if (zneg)
				check_gap("zneg spacing", i, last_neg, 8);
			prev_pos = zpos;
			prev_neg = zneg;
		end
		if (n_pos == 0)
		begin
			$display("no zpos pulse seen at 3.5 MHz");
			err_cnt++;
		end
		end_test("3.5 MHz no stall");

		// test 3 holds a turbo request off until a refresh edge
		turbo    = 2'b01;
		last_pos = -1;
		for (i = 0; i < 48; i++)
		begin
			tick();
			if (zpos)
				check_gap("zpos spacing before refresh", i, last_pos, 8);
		end
		rfsh_n = 1'b0; // long enough to span one zpos sample
		for (i = 0; i < 12; i++)
			tick();
		rfsh_n   = 1'b1;
		last_pos = -1;
		n_pos    = 0;
		for (i = 0; i < T3_CYCLES - 60; i++)
		begin
			tick();
			if (zpos && i >= 16) // let the switch settle first
			begin
				check_gap("zpos spacing after refresh", i, last_pos, 4);
				n_pos++;
			end
		end
		if (n_pos == 0)
		begin
			$display("no zpos pulse seen after the turbo switch");
			err_cnt++;
		end
		end_test("turbo switch");

		// test 4 lets video steal every other cycle while the cpu keeps asking
		video_active = 1'b1;
		cpu_req      = 1'b1;
		for (i = 0; i < 16; i++)
			tick();
		n_pos   = 0;
		n_neg   = 0;
		n_grant = 0;
		for (i = 0; i < 64; i++) // 16 DRAM cycles with half of them stalled
		begin
			tick();
			n_pos   += int'(zpos);
			n_neg   += int'(zneg);
			n_grant += int'(cpu_grant);
			if (cpu_grant && m_vid_owner)
			begin
				$display("cpu_grant given in a video slot at %0t", $time);
				err_cnt++;
			end
		end
		if (n_pos != 8)
			report_value("zpos count", 32'(n_pos), 32'd8);
		if (n_neg != 8)
			report_value("zneg count", 32'(n_neg), 32'd8);
		if (n_grant != 8)
			report_value("cpu_grant count", 32'(n_grant), 32'd8);
		video_active = 1'b0;
		cpu_req      = 1'b0;
		for (i = 0; i < T4_CYCLES - 80; i++)
			tick();
		end_test("video contention");

		// test 5 is fully random and left to the model
		rfsh_left = 0;
		vid_left  = 0;
		n_pos     = 0;
		for (i = 0; i < T5_CYCLES; i++)
		begin
			tick();
			n_pos += int'(zpos);
			rnd = $random(seed);
			if (rnd[5:0] == 6'd0)
				turbo = rnd[9:8];
			if (rfsh_left > 0)
			begin
				rfsh_n = 1'b0;
				rfsh_left--;
			end
			else
			begin
				rfsh_n = 1'b1;
				if (rnd[14:10] == 5'd0)
					rfsh_left = int'(rnd[19:16]) + 1; // 1 to 16 cycles low
			end
			if (vid_left > 0)
				vid_left--;
			else
			begin
				video_active = ~video_active;
				vid_left     = 16 + int'(rnd[27:20]);
			end
			rnd     = $random(seed);
			cpu_req = rnd[3];
		end
		if (n_pos == 0)
		begin
			$display("no zpos pulse seen during the soak");
			err_cnt++;
		end
		end_test("random soak");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			test_num - 1, failed_tests, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/zclk_pkg.sv
design/dram_phase.sv
design/slot_arbiter.sv
design/zclock.sv
design/zclk_top.sv
tests/tb_zclk.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_zclk
DUT_TOP   ?= zclk_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ** PASS **

.PHONY: all lint sim clean

all: sim

# static checks on the design top
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(DUT_TOP)

# build and run, the exit status comes from the search for the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
